// File: logic/wb_pkg.sv
package wb_pkg;

    // bus word and register address widths
    localparam int WB_DATA_W = 32;
    localparam int WB_ADDR_W = 3;

    typedef logic [WB_DATA_W-1:0] wb_data_t;  // one bus data word
    typedef logic [WB_ADDR_W-1:0] wb_addr_t;  // word address, no byte offset

    // register map, word addresses
    localparam wb_addr_t REG_OPA_LO = 3'd0;
    localparam wb_addr_t REG_OPA_HI = 3'd1;
    localparam wb_addr_t REG_OPB_LO = 3'd2;
    localparam wb_addr_t REG_OPB_HI = 3'd3;
    localparam wb_addr_t REG_CTRL   = 3'd4;
    localparam wb_addr_t REG_SUM_LO = 3'd5;  // read only
    localparam wb_addr_t REG_SUM_HI = 3'd6;  // read only
    localparam wb_addr_t REG_STATUS = 3'd7;  // read only

    // control word bits
    localparam int CTRL_GO  = 0;  // launch on write
    localparam int CTRL_SUB = 1;  // 1 = subtract
    localparam int CTRL_CIN = 2;  // carry in, or borrow when subtracting

    // status word bits
    localparam int STAT_DONE = 0;
    localparam int STAT_COUT = 1;
    localparam int STAT_OVF  = 2;

endpackage

// File: logic/adder_pkg.sv
package adder_pkg;

    // datapath width the top level uses unless told otherwise
    localparam int WIDTH_DEFAULT = 64;

    // full width operand and result words as seen by the register file
    typedef logic [WIDTH_DEFAULT-1:0] operand_t;
    typedef logic [WIDTH_DEFAULT-1:0] sum_t;

    // operation select carried with each request
    typedef enum logic {
        OP_ADD = 1'b0,
        OP_SUB = 1'b1
    } add_op_e;

endpackage

// File: logic/exec_if.sv
`timescale 1ns/1ns

interface exec_if import adder_pkg::*; #(
    parameter int WIDTH = WIDTH_DEFAULT
) ();

    // request, one cycle pulse from decode
    logic             req_valid;
    logic [WIDTH-1:0] opa;
    logic [WIDTH-1:0] opb;
    add_op_e          op;
    logic             cin;  // raw carry or borrow bit from the control word

    // completed result from execute
    logic             res_valid;
    logic [WIDTH-1:0] sum;
    logic             cout;
    logic             ovf;

    modport decode_mp (
        output req_valid, opa, opb, op, cin
    );

    modport exec_mp (
        input  req_valid, opa, opb, op, cin,
        output res_valid, sum, cout, ovf
    );

    modport result_mp (
        input res_valid, sum, cout, ovf
    );

endinterface

// File: logic/kogge_stone_adder.sv
`timescale 1ns/1ns

module kogge_stone_adder #(
    parameter int WIDTH = 64
) (
    input  logic [WIDTH-1:0] a,
    input  logic [WIDTH-1:0] b,
    input  logic             cin,
    output logic [WIDTH-1:0] sum,
    output logic             cout
);

    // position 0 holds the carry in, positions 1..WIDTH hold the operand bits
    localparam int N      = WIDTH + 1;
    localparam int LEVELS = $clog2(N);  // doubling spans until all of N is covered

    // group generate per level, level 0 is the bitwise term
    wire [LEVELS:0][N-1:0] gk;
    // group propagate, only the levels that feed another level
    wire [LEVELS-1:0][N-1:0] pk;

    // bitwise generate and propagate
    // cin acts as a generate that nothing can kill
    assign gk[0] = {a & b, cin};
    assign pk[0] = {a ^ b, 1'b0};

    genvar k;
    genvar i;
    generate
        for (k = 0; k < LEVELS; k++) begin : g_level
            localparam int SPAN = 1 << k;

            for (i = 0; i < N; i++) begin : g_pos
                if (i >= SPAN) begin : g_merge
                    // black cell, combine with the group SPAN positions lower
                    assign gk[k+1][i] = gk[k][i] | (pk[k][i] & gk[k][i-SPAN]);
                    if (k < LEVELS - 1) begin : g_prop
                        assign pk[k+1][i] = pk[k][i] & pk[k][i-SPAN];
                    end
                end else begin : g_pass
                    // group already reaches position 0, carry is final
                    assign gk[k+1][i] = gk[k][i];
                    if (k < LEVELS - 1) begin : g_prop
                        assign pk[k+1][i] = pk[k][i];
                    end
                end
            end
        end
    endgenerate

    // gk[LEVELS][i] is the carry into operand bit i
    assign sum  = pk[0][WIDTH:1] ^ gk[LEVELS][WIDTH-1:0];
    assign cout = gk[LEVELS][WIDTH];  // generate over every position

endmodule

// File: logic/wb_reg_decode.sv
`timescale 1ns/1ns

module wb_reg_decode import wb_pkg::*, adder_pkg::*; #(
    parameter int WIDTH = WIDTH_DEFAULT
) (
    input  logic      clk,
    input  logic      arst_n,
    input  logic      cyc,
    input  logic      stb,
    input  logic      we,
    input  wb_addr_t  adr,
    input  wb_data_t  dat_i,
    input  wb_data_t  status,
    input  sum_t      sum,
    output wb_data_t  dat_o,
    output logic      ack,
    exec_if.decode_mp req
);

    localparam int HI = $bits(operand_t) - 1;  // top bit of a full operand

    operand_t opa_q;
    operand_t opb_q;
    wb_data_t ctrl_q;
    logic     served_q;  // current strobe already acked
    logic     go_q;
    logic     take;
    wb_data_t rd_data;

    // accept a transfer once per strobe
    assign take = cyc && stb && !served_q;

    // classic handshake, ack one cycle after the request is seen
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ack      <= 1'b0;
            served_q <= 1'b0;
        end else begin
            ack <= take;
            if (take) begin
                served_q <= 1'b1;
            end else if (!(cyc && stb)) begin
                served_q <= 1'b0;  // strobe dropped or cycle ended
            end
        end
    end

    // register writes land on the acking edge
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            opa_q  <= '0;
            opb_q  <= '0;
            ctrl_q <= '0;
            go_q   <= 1'b0;
        end else begin
            go_q <= 1'b0;
            if (take && we) begin
                case (adr)
                    REG_OPA_LO: opa_q[WB_DATA_W-1:0]  <= dat_i;
                    REG_OPA_HI: opa_q[HI:WB_DATA_W]   <= dat_i;
                    REG_OPB_LO: opb_q[WB_DATA_W-1:0]  <= dat_i;
                    REG_OPB_HI: opb_q[HI:WB_DATA_W]   <= dat_i;
                    REG_CTRL: begin
                        ctrl_q <= dat_i;
                        go_q   <= dat_i[CTRL_GO];  // launch next cycle
                    end
                    default: ;  // result and status are read only
                endcase
            end
        end
    end

    // read mux
    always_comb begin
        case (adr)
            REG_OPA_LO: rd_data = opa_q[WB_DATA_W-1:0];
            REG_OPA_HI: rd_data = opa_q[HI:WB_DATA_W];
            REG_OPB_LO: rd_data = opb_q[WB_DATA_W-1:0];
            REG_OPB_HI: rd_data = opb_q[HI:WB_DATA_W];
            REG_CTRL:   rd_data = ctrl_q;
            REG_SUM_LO: rd_data = sum[WB_DATA_W-1:0];
            REG_SUM_HI: rd_data = sum[HI:WB_DATA_W];
            REG_STATUS: rd_data = status;
            default:    rd_data = '0;
        endcase
    end

    // read data registered alongside ack
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            dat_o <= '0;
        end else if (take && !we) begin
            dat_o <= rd_data;
        end
    end

    // request built from the stored operands and control word
    assign req.req_valid = go_q;
    assign req.opa       = opa_q[WIDTH-1:0];  // upper word unused at 32 bits
    assign req.opb       = opb_q[WIDTH-1:0];
    assign req.op        = ctrl_q[CTRL_SUB] ? OP_SUB : OP_ADD;
    assign req.cin       = ctrl_q[CTRL_CIN];

endmodule

// File: logic/add_execute.sv
`timescale 1ns/1ns

module add_execute import adder_pkg::*; #(
    parameter int WIDTH = WIDTH_DEFAULT
) (
    input  logic    clk,
    input  logic    arst_n,
    exec_if.exec_mp ex
);

    logic [WIDTH-1:0] a_q;
    logic [WIDTH-1:0] b_q;
    logic             cin_q;
    logic             v_q;
    logic             sub;
    logic [WIDTH-1:0] add_sum;
    logic             add_cout;
    logic             ovf;

    assign sub = (ex.op == OP_SUB);

    // valid bits for both stages
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            v_q          <= 1'b0;
            ex.res_valid <= 1'b0;
        end else begin
            v_q          <= ex.req_valid;
            ex.res_valid <= v_q;
        end
    end

    // stage 1, subtract as a + ~b + ~borrow
    always_ff @(posedge clk) begin
        if (ex.req_valid) begin
            a_q   <= ex.opa;
            b_q   <= sub ? ~ex.opb : ex.opb;
            cin_q <= ex.cin ^ sub;
        end
    end

    kogge_stone_adder #(.WIDTH(WIDTH)) u_adder (
        .a    (a_q),
        .b    (b_q),
        .cin  (cin_q),
        .sum  (add_sum),
        .cout (add_cout)
    );

    // signed overflow on the conditioned inputs
    assign ovf = (a_q[WIDTH-1] == b_q[WIDTH-1]) && (add_sum[WIDTH-1] != a_q[WIDTH-1]);

    // stage 2, adder output register
    always_ff @(posedge clk) begin
        if (v_q) begin
            ex.sum  <= add_sum;
            ex.cout <= add_cout;
            ex.ovf  <= ovf;
        end
    end

endmodule

// File: logic/result_capture.sv
`timescale 1ns/1ns

module result_capture import wb_pkg::*, adder_pkg::*; #(
    parameter int WIDTH = WIDTH_DEFAULT
) (
    input  logic      clk,
    input  logic      arst_n,
    input  logic      go,  // launch pulse, same as req_valid
    exec_if.result_mp res,
    output sum_t      sum,
    output wb_data_t  status
);

    logic [WIDTH-1:0] sum_q;
    logic             cout_q;
    logic             ovf_q;
    logic             done_q;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            sum_q  <= '0;
            cout_q <= 1'b0;
            ovf_q  <= 1'b0;
            done_q <= 1'b0;
        end else begin
            if (go) begin
                done_q <= 1'b0;  // new operation in flight
            end
            // an older completion still sets done
            // the host waits on each launch before the next
            if (res.res_valid) begin
                sum_q  <= res.sum;
                cout_q <= res.cout;
                ovf_q  <= res.ovf;
                done_q <= 1'b1;
            end
        end
    end

    // zero extended when the datapath is narrower than the register map
    assign sum = sum_t'(sum_q);

    always_comb begin
        status            = '0;
        status[STAT_DONE] = done_q;
        status[STAT_COUT] = cout_q;
        status[STAT_OVF]  = ovf_q;
    end

endmodule

// File: logic/ks_adder_top.sv
`timescale 1ns/1ns

module ks_adder_top import wb_pkg::*, adder_pkg::*; #(
    parameter int WIDTH = WIDTH_DEFAULT
) (
    input  logic     clk,
    input  logic     arst_n,
    input  logic     cyc,
    input  logic     stb,
    input  logic     we,
    input  wb_addr_t adr,
    input  wb_data_t dat_i,
    output wb_data_t dat_o,
    output logic     ack
);

    sum_t     cap_sum;     // latest result for SUM_LO/HI reads
    wb_data_t cap_status;  // packed done, cout, ovf

    exec_if #(.WIDTH(WIDTH)) u_exec_if ();

    wb_reg_decode #(.WIDTH(WIDTH)) u_decode (
        .clk    (clk),
        .arst_n (arst_n),
        .cyc    (cyc),
        .stb    (stb),
        .we     (we),
        .adr    (adr),
        .dat_i  (dat_i),
        .status (cap_status),
        .sum    (cap_sum),
        .dat_o  (dat_o),
        .ack    (ack),
        .req    (u_exec_if.decode_mp)
    );

    add_execute #(.WIDTH(WIDTH)) u_execute (
        .clk    (clk),
        .arst_n (arst_n),
        .ex     (u_exec_if.exec_mp)
    );

    result_capture #(.WIDTH(WIDTH)) u_result (
        .clk    (clk),
        .arst_n (arst_n),
        .go     (u_exec_if.req_valid),
        .res    (u_exec_if.result_mp),
        .sum    (cap_sum),
        .status (cap_status)
    );

endmodule

// File: dv/tb_ks_adder.sv
`timescale 1ns/1ns

module tb_ks_adder import wb_pkg::*, adder_pkg::*; ();

    localparam int ACK_TIMEOUT  = 16;  // cycles to wait for one ack
    localparam int DONE_TIMEOUT = 20;  // status polls before giving up
    localparam int N_RANDOM     = 40;

    logic     clk;
    logic     arst_n;
    logic     cyc;
    logic     stb;
    logic     we;
    wb_addr_t adr;
    wb_data_t dat_i;
    wb_data_t dat_o;
    logic     ack;

    logic [31:0] rng_state;
    operand_t    cur_a;  // operands as last written to the DUT
    operand_t    cur_b;

    ks_adder_top #(.WIDTH(WIDTH_DEFAULT)) u_ks_adder_top (
        .clk    (clk),
        .arst_n (arst_n),
        .cyc    (cyc),
        .stb    (stb),
        .we     (we),
        .adr    (adr),
        .dat_i  (dat_i),
        .dat_o  (dat_o),
        .ack    (ack)
    );

    always #50 clk = ~clk;

    function automatic logic [31:0] next_random();
        logic [31:0] x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    function automatic operand_t random_operand();
        operand_t v;
        v[63:32] = next_random();
        v[31:0]  = next_random();
        return v;
    endfunction

    function automatic wb_data_t ctrl_word(input logic go, input logic sub, input logic cin);
        wb_data_t w;
        w           = '0;
        w[CTRL_GO]  = go;
        w[CTRL_SUB] = sub;
        w[CTRL_CIN] = cin;
        return w;
    endfunction

    task automatic abort_run();
        $display("CHECKS FAILED");
        $fatal(1, "simulation stopped at the first failure");
    endtask

    task automatic check_sum(input string name, input sum_t got, input sum_t exp);
        if (got !== exp) begin
            $display("[ERROR] %s got 0x%h expected 0x%h", name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("[ERROR] %s got 0x%h expected 0x%h", name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_word(input string name, input wb_data_t got, input wb_data_t exp);
        if (got !== exp) begin
            $display("[ERROR] %s got 0x%h expected 0x%h", name, got, exp);
            abort_run();
        end
    endtask

    // one classic transfer driven on a rising edge and sampled on the falling edge
    task automatic bus_cycle(input logic wr, input wb_addr_t a, input wb_data_t d,
                             output wb_data_t q);
        int n;
        n = 0;
        @(posedge clk);
        cyc   <= 1'b1;
        stb   <= 1'b1;
        we    <= wr;
        adr   <= a;
        dat_i <= d;
        do begin
            @(negedge clk);
            n++;
        end while (!ack && n < ACK_TIMEOUT);
        if (!ack) begin
            $display("no ack from address %0d within %0d cycles", a, ACK_TIMEOUT);
            abort_run();
        end
        q = dat_o;  // valid while ack is high
        @(posedge clk);
        cyc <= 1'b0;
        stb <= 1'b0;
        we  <= 1'b0;
        @(negedge clk);
        check_flag("ack after transfer", ack, 1'b0);  // ack lasts a single cycle
    endtask

    task automatic wb_write(input wb_addr_t a, input wb_data_t d);
        wb_data_t unused;
        bus_cycle(1'b1, a, d, unused);
    endtask

    task automatic wb_read(input wb_addr_t a, output wb_data_t q);
        bus_cycle(1'b0, a, '0, q);
    endtask

    task automatic wait_done(output wb_data_t st);
        int polls;
        polls = 0;
        do begin
            wb_read(REG_STATUS, st);
            polls++;
        end while (!st[STAT_DONE] && polls < DONE_TIMEOUT);
        if (!st[STAT_DONE]) begin
            $display("done never set after %0d status polls", DONE_TIMEOUT);
            abort_run();
        end
    endtask

    // reference model with subtract as a + ~b + ~borrow on a 65 bit sum
    task automatic model_op(input operand_t a, input operand_t b, input logic sub,
                            input logic cin, output sum_t s, output logic c, output logic v);
        logic [64:0] full;
        operand_t    b_in;
        logic        c_in;
        b_in = sub ? ~b : b;
        c_in = sub ? ~cin : cin;
        full = {1'b0, a} + {1'b0, b_in} + 65'(c_in);
        s    = full[63:0];
        c    = full[64];
        v    = (a[63] == b_in[63]) && (s[63] != a[63]);
    endtask

    task automatic write_operands(input operand_t a, input operand_t b);
        wb_write(REG_OPA_LO, a[31:0]);
        wb_write(REG_OPA_HI, a[63:32]);
        wb_write(REG_OPB_LO, b[31:0]);
        wb_write(REG_OPB_HI, b[63:32]);
        cur_a = a;
        cur_b = b;
    endtask

    task automatic check_result(input logic sub, input logic cin);
        wb_data_t st;
        wb_data_t lo;
        wb_data_t hi;
        sum_t     exp_s;
        logic     exp_c;
        logic     exp_v;
        wait_done(st);
        wb_read(REG_SUM_LO, lo);
        wb_read(REG_SUM_HI, hi);
        model_op(cur_a, cur_b, sub, cin, exp_s, exp_c, exp_v);
        check_sum("sum", {hi, lo}, exp_s);
        check_flag("cout", st[STAT_COUT], exp_c);
        check_flag("ovf", st[STAT_OVF], exp_v);
    endtask

    task automatic run_op(input operand_t a, input operand_t b, input logic sub, input logic cin);
        wb_data_t st;
        write_operands(a, b);
        wb_write(REG_CTRL, ctrl_word(1'b1, sub, cin));
        wb_read(REG_STATUS, st);  // result still two cycles out
        check_flag("done after go", st[STAT_DONE], 1'b0);
        check_result(sub, cin);
    endtask

    initial begin
        wb_data_t    rd;
        wb_data_t    wr;
        logic [31:0] rnd;
        operand_t    x;
        int          i;
        clk       = 1'b0;
        arst_n    = 1'b0;
        cyc       = 1'b0;
        stb       = 1'b0;
        we        = 1'b0;
        adr       = '0;
        dat_i     = '0;
        rng_state = 32'd66399;
        cur_a     = '0;
        cur_b     = '0;
        repeat (10) @(posedge clk);
        arst_n <= 1'b1;

        for (i = 0; i < 8; i++) begin
            wb_read(wb_addr_t'(i), rd);
            check_word($sformatf("reg %0d after reset", i), rd, '0);
        end

        // operand and control readback with go kept low
        for (i = 0; i < 4; i++) begin
            wr = next_random();
            wb_write(wb_addr_t'(i), wr);
            wb_read(wb_addr_t'(i), rd);
            check_word($sformatf("reg %0d readback", i), rd, wr);
        end
        wr          = next_random();
        wr[CTRL_GO] = 1'b0;
        wb_write(REG_CTRL, wr);
        wb_read(REG_CTRL, rd);
        check_word("ctrl readback", rd, wr);

        for (i = 0; i < N_RANDOM; i++) begin
            rnd = next_random();
            run_op(random_operand(), random_operand(), 1'b0, rnd[0]);
        end

        for (i = 0; i < N_RANDOM; i++) begin
            rnd = next_random();
            run_op(random_operand(), random_operand(), 1'b1, rnd[0]);
        end
        x = random_operand();
        run_op(x, x, 1'b1, 1'b0);  // equal operands
        run_op(x, x, 1'b1, 1'b1);
        run_op('1, '1, 1'b1, 1'b0);
        run_op('0, '1, 1'b1, 1'b1);

        run_op('1, 64'd1, 1'b0, 1'b1);
        run_op(64'h0000_0000_FFFF_FFFF, 64'd1, 1'b0, 1'b0);  // ripple into upper word
        run_op(64'h7FFF_FFFF_FFFF_FFFF, 64'd1, 1'b0, 1'b0);
        run_op(64'h8000_0000_0000_0000, 64'd1, 1'b1, 1'b0);

        // two launches with no status poll between them
        for (i = 0; i < 10; i++) begin
            write_operands(random_operand(), random_operand());
            rnd = next_random();
            wb_write(REG_CTRL, ctrl_word(1'b1, rnd[0], rnd[1]));
            wr = next_random();
            wb_write(REG_OPB_LO, wr);
            cur_b[31:0] = wr;
            wb_write(REG_CTRL, ctrl_word(1'b1, rnd[2], rnd[3]));
            check_result(rnd[2], rnd[3]);
        end

        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

// File: build.f
logic/wb_pkg.sv
logic/adder_pkg.sv
logic/exec_if.sv
logic/kogge_stone_adder.sv
logic/wb_reg_decode.sv
logic/add_execute.sv
logic/result_capture.sv
logic/ks_adder_top.sv
dv/tb_ks_adder.sv

// File: Makefile
TOP := tb_ks_adder
LOG := sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timescale 1ns/1ns -f build.f --top-module $(TOP) --Mdir obj_dir -o $(TOP)

run: compile
	./obj_dir/$(TOP) 2>&1 | tee $(LOG)
	@grep -q "ALL CHECKS PASSED" $(LOG) && echo "simulation passed" || \
		(echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf obj_dir $(LOG)
